//--- common/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// io address is {addr_hi, addr_lo[3:0]}
`define IO_ADDR_W       8
`define BANK_W          10
`define ROM_EXT_W       9
`define ADDR_EXT_W      7
`define RAM_MASK_W      4

// legacy 2001 bank registers
`define REG_LINEAR      8'hC0
`define REG_RAM_BANK    8'hC1
`define REG_ROM0        8'hC2
`define REG_ROM1        8'hC3

// 2003 extended registers
`define REG_MEM_CTRL    8'hCE
`define REG_RAM_BANK_L  8'hD0
`define REG_RAM_BANK_H  8'hD1
`define REG_ROM0_L      8'hD2
`define REG_ROM0_H      8'hD3
`define REG_ROM1_L      8'hD4
`define REG_ROM1_H      8'hD5

// cartridge extension registers
`define REG_POW_CNT      8'hE2
`define REG_BANK_MASK_LO 8'hE4
`define REG_BANK_MASK_HI 8'hE5
`define REG_EMU_CNT      8'hE6

`define POW_UNLOCK      8'hDD

// flash command bytes
`define FLASH_CMD_AA      8'hAA
`define FLASH_CMD_55      8'h55
`define FLASH_CMD_FAST    8'h20
`define FLASH_CMD_WRITE   8'hA0
`define FLASH_CMD_EXIT    8'h90
`define FLASH_CMD_ERASE_A 8'h10
`define FLASH_CMD_ERASE_B 8'h30

`endif

//--- common/cart_bus_pkg.sv
`include "cart_params.svh"

package cart_bus_pkg;

    // console side, sampled on SClk
    typedef struct packed {
        logic        n_sel;
        logic        n_io;
        logic        n_oe;
        logic        n_we;
        logic [3:0]  addr_hi;
        logic [8:0]  addr_lo;
        logic [15:0] wdata;
    } bus_req_t;

    // external memory pins
    typedef struct packed {
        logic [`ADDR_EXT_W-1:0] addr_ext;
        logic                   n_psram1_sel;
        logic                   n_psram2_sel;
        logic                   n_sram_sel;
        logic                   psram_n_lb;
        logic                   psram_n_ub;
    } mem_sel_t;

endpackage

//--- common/cart_regs_pkg.sv
`include "cart_params.svh"

package cart_regs_pkg;

    typedef struct packed {
        logic [`BANK_W-1:0]     ram_bank;
        logic [`BANK_W-1:0]     rom0_bank;
        logic [`BANK_W-1:0]     rom1_bank;
        logic [7:0]             linear_off;
        logic                   self_flash;
        logic                   enable_sram;
        logic [`ROM_EXT_W-1:0]  rom_mask;
        logic [`RAM_MASK_W-1:0] ram_mask;
        logic                   apply_rom0;
        logic                   apply_rom1;
        logic                   apply_ram;
    } bank_regs_t;

    // same bit order as EMU_CNT[3:0]
    typedef struct packed {
        logic       enable_rom_8bit_bus;
        logic       enable_flash_emu;
        logic [1:0] eeprom_size;
    } emu_ctrl_t;

    typedef enum logic [2:0] {
        wait_aa,
        wait_55,
        cmd,
        fast_mode,
        fast_write,
        single_write,
        erase
    } flash_emu_state_e;

    typedef struct packed {
        logic rom_space;
        logic ram_area;
        logic psram_hit;
        logic psram_hi_lane;
        logic byte_area;
    } map_info_t;

endpackage

//--- hw/io_regs.sv
`include "cart_params.svh"

module io_regs (
    input  logic                     SClk,
    input  logic                     rst_n,
    input  cart_bus_pkg::bus_req_t   bus,
    output cart_regs_pkg::bank_regs_t regs,
    output cart_regs_pkg::emu_ctrl_t  emu,
    output logic [7:0]               reg_rdata,
    output logic                     reg_hit
);

    logic [`IO_ADDR_W-1:0] reg_addr;
    logic [7:0]            wd;
    logic                  io_wr;
    logic                  ext_bank_wr;
    logic [7:0]            pow_cnt;

    // POW_CNT bits other than enable_sram
    logic mcu_reset, boot0, ext2003, ext2001, extnile, tf_power, fastclk;

    assign reg_addr = {bus.addr_hi, bus.addr_lo[3:0]};
    assign wd       = bus.wdata[7:0];
    assign io_wr    = ~bus.n_sel & ~bus.n_io & ~bus.n_we;
    assign pow_cnt  = {mcu_reset, regs.enable_sram, boot0, ext2003,
                       ext2001, extnile, tf_power, fastclk};

    always_ff @(posedge SClk or negedge rst_n) begin
        if (!rst_n) begin
            regs.ram_bank    <= 10'h3FF;
            regs.rom0_bank   <= 10'h3FF;
            regs.rom1_bank   <= 10'h3FF;
            regs.linear_off  <= 8'hFF;
            regs.self_flash  <= 1'b0;
            regs.enable_sram <= 1'b1;
            regs.rom_mask    <= 9'h1FF;
            regs.ram_mask    <= 4'hF;
            regs.apply_rom0  <= 1'b1;
            regs.apply_rom1  <= 1'b1;
            regs.apply_ram   <= 1'b1;
            {mcu_reset, boot0, ext2003, ext2001} <= 4'b1011;
            {extnile, tf_power, fastclk}         <= 3'b101;
            emu <= '0;
        end else if (io_wr) begin
            case (reg_addr)
                `REG_LINEAR:     regs.linear_off <= wd;
                `REG_RAM_BANK:   regs.ram_bank[7:0] <= wd;
                `REG_ROM0:       regs.rom0_bank[7:0] <= wd;
                `REG_ROM1:       regs.rom1_bank[7:0] <= wd;
                `REG_RAM_BANK_L: if (ext2003) regs.ram_bank[7:0] <= wd;
                `REG_RAM_BANK_H: if (ext2003) regs.ram_bank[9:8] <= wd[1:0];
                `REG_ROM0_L:     if (ext2003) regs.rom0_bank[7:0] <= wd;
                `REG_ROM0_H:     if (ext2003) regs.rom0_bank[9:8] <= wd[1:0];
                `REG_ROM1_L:     if (ext2003) regs.rom1_bank[7:0] <= wd;
                `REG_ROM1_H:     if (ext2003) regs.rom1_bank[9:8] <= wd[1:0];
                `REG_MEM_CTRL:   if (ext2003) regs.self_flash <= wd[0];
                `REG_BANK_MASK_LO: if (extnile) regs.rom_mask[7:0] <= wd;
                `REG_BANK_MASK_HI: if (extnile) begin
                    regs.ram_mask    <= wd[7:4];
                    regs.apply_ram   <= wd[3];
                    regs.apply_rom1  <= wd[2];
                    regs.apply_rom0  <= wd[1];
                    regs.rom_mask[8] <= wd[0];
                end
                // unlock value always gets through
                `REG_POW_CNT: if (extnile || wd == `POW_UNLOCK) begin
                    {mcu_reset, regs.enable_sram, boot0, ext2003} <= wd[7:4];
                    {ext2001, extnile, tf_power, fastclk}         <= wd[3:0];
                end
                `REG_EMU_CNT: if (extnile) emu <= wd[3:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = 8'h00;
        case (reg_addr)
            `REG_LINEAR:       reg_rdata = regs.linear_off;
            `REG_RAM_BANK,
            `REG_RAM_BANK_L:   reg_rdata = regs.ram_bank[7:0];
            `REG_ROM0,
            `REG_ROM0_L:       reg_rdata = regs.rom0_bank[7:0];
            `REG_ROM1,
            `REG_ROM1_L:       reg_rdata = regs.rom1_bank[7:0];
            `REG_RAM_BANK_H:   reg_rdata = {6'h0, regs.ram_bank[9:8]};
            `REG_ROM0_H:       reg_rdata = {6'h0, regs.rom0_bank[9:8]};
            `REG_ROM1_H:       reg_rdata = {6'h0, regs.rom1_bank[9:8]};
            `REG_MEM_CTRL:     reg_rdata = {7'h0, regs.self_flash};
            `REG_POW_CNT:      reg_rdata = pow_cnt;
            `REG_BANK_MASK_LO: reg_rdata = regs.rom_mask[7:0];
            `REG_BANK_MASK_HI: reg_rdata = {regs.ram_mask, regs.apply_ram, regs.apply_rom1,
                                            regs.apply_rom0, regs.rom_mask[8]};
            `REG_EMU_CNT:      reg_rdata = {4'h0, emu};
            default:           reg_hit = 1'b0;
        endcase
    end

    assign ext_bank_wr = io_wr && (reg_addr inside {`REG_RAM_BANK_L, `REG_RAM_BANK_H,
        `REG_ROM0_L, `REG_ROM0_H, `REG_ROM1_L, `REG_ROM1_H});

    // locked 2003 bank writes must leave every bank untouched
    a_ext_locked: assert property (@(posedge SClk) disable iff (!rst_n)
        ext_bank_wr && !ext2003 |=>
            $stable({regs.ram_bank, regs.rom0_bank, regs.rom1_bank}))
        else $error("extended bank write went through with ext2003 clear");

endmodule

//--- mapper/bank_mapper.sv
`include "cart_params.svh"

module bank_mapper (
    input  cart_bus_pkg::bus_req_t    bus,
    input  cart_regs_pkg::bank_regs_t regs,
    input  cart_regs_pkg::emu_ctrl_t  emu,
    input  logic                      pass_read,
    input  logic                      pass_write,
    output cart_bus_pkg::mem_sel_t    mem,
    output cart_regs_pkg::map_info_t  info
);

    logic [`ROM_EXT_W-1:0]  rom_sel, rom_masked;
    logic [`RAM_MASK_W-1:0] ram_masked;
    logic rom_space, ram_space, ram_area, apply_mask;
    logic psram1_addr, psram2_addr, sram_addr;
    logic mem_cyc, psram_en, byte_area;

    always_comb begin
        rom_sel    = '0;
        rom_space  = 1'b0;
        ram_space  = 1'b0;
        ram_area   = 1'b0;
        apply_mask = 1'b1;
        case (bus.addr_hi)
            4'h0: ;
            4'h1: begin
                // save area that flash emulation remaps into rom space
                rom_space  = regs.self_flash;
                ram_space  = ~regs.self_flash;
                rom_sel    = regs.ram_bank[`ROM_EXT_W-1:0];
                ram_area   = 1'b1;
                apply_mask = regs.apply_ram;
            end
            4'h2: begin
                rom_space  = 1'b1;
                rom_sel    = regs.rom0_bank[`ROM_EXT_W-1:0];
                apply_mask = regs.apply_rom0;
            end
            4'h3: begin
                rom_space  = 1'b1;
                rom_sel    = regs.rom1_bank[`ROM_EXT_W-1:0];
                apply_mask = regs.apply_rom1;
            end
            default: begin
                rom_space  = 1'b1;
                rom_sel    = {regs.linear_off[4:0], bus.addr_hi};
                apply_mask = 1'b0;
            end
        endcase
    end

    assign rom_masked = apply_mask ? (rom_sel & regs.rom_mask) : rom_sel;
    assign ram_masked = apply_mask ? (regs.ram_bank[`RAM_MASK_W-1:0] & regs.ram_mask)
                                   : regs.ram_bank[`RAM_MASK_W-1:0];

    assign psram1_addr = rom_space && rom_masked[8:7] == 2'd0;
    assign psram2_addr = rom_space && rom_masked[8:7] == 2'd1;
    assign sram_addr   = ram_space && !ram_masked[3] && regs.enable_sram;

    assign mem_cyc   = ~bus.n_sel & bus.n_io;
    assign psram_en  = mem_cyc & ((~bus.n_oe & pass_read) | (~bus.n_we & pass_write));
    assign byte_area = ram_area | emu.enable_rom_8bit_bus;

    always_comb begin
        mem.addr_ext[2:0] = rom_space ? rom_masked[2:0] : ram_masked[2:0];
        // sram ignores everything above bit 2
        mem.addr_ext[6:3] = rom_masked[6:3];
        mem.n_psram1_sel  = ~(psram_en & psram1_addr);
        mem.n_psram2_sel  = ~(psram_en & psram2_addr);
        mem.n_sram_sel    = ~(mem_cyc & sram_addr & (~bus.n_oe | ~bus.n_we));
        mem.psram_n_lb    = byte_area & bus.addr_lo[0];
        mem.psram_n_ub    = byte_area & ~bus.addr_lo[0];
    end

    always_comb begin
        info.rom_space     = rom_space;
        info.ram_area      = ram_area;
        info.psram_hit     = psram1_addr | psram2_addr;
        info.psram_hi_lane = (psram1_addr | psram2_addr) & byte_area & bus.addr_lo[0];
        info.byte_area     = byte_area;
    end

    always_comb begin
        a_one_sel: assert final ($onehot0(~{mem.n_psram1_sel, mem.n_psram2_sel,
                                           mem.n_sram_sel}))
            else $error("more than one chip select low");
    end

endmodule

//--- mapper/flash_emu_fsm.sv
`include "cart_params.svh"

module flash_emu_fsm (
    input  logic                     SClk,
    input  logic                     rst_n,
    input  cart_bus_pkg::bus_req_t   bus,
    input  cart_regs_pkg::emu_ctrl_t emu,
    input  cart_regs_pkg::map_info_t info,
    output logic                     pass_read,
    output logic                     pass_write,
    output logic                     catch_read,
    output logic [7:0]               catch_value
);

    import cart_regs_pkg::*;

    flash_emu_state_e state, state_nxt;
    logic [7:0]       wd;
    logic             psram_wr, emu_active;

    assign wd       = bus.wdata[7:0];
    // steps on the raw psram hit even when the write itself is blocked
    assign psram_wr = ~bus.n_sel & bus.n_io & ~bus.n_we & info.psram_hit;

    always_comb begin
        state_nxt = state;
        case (state)
            wait_aa:      if (wd == `FLASH_CMD_AA) state_nxt = wait_55;
            wait_55:      state_nxt = (wd == `FLASH_CMD_55) ? cmd : wait_aa;
            cmd: begin
                case (wd)
                    `FLASH_CMD_FAST:    state_nxt = fast_mode;
                    `FLASH_CMD_WRITE:   state_nxt = single_write;
                    `FLASH_CMD_ERASE_A,
                    `FLASH_CMD_ERASE_B: state_nxt = erase;
                    default:            state_nxt = wait_aa;
                endcase
            end
            fast_mode: begin
                if (wd == `FLASH_CMD_WRITE)
                    state_nxt = fast_write;
                else if (wd == `FLASH_CMD_EXIT)
                    state_nxt = wait_aa;
            end
            fast_write:   state_nxt = fast_mode;
            single_write: state_nxt = wait_aa;
            erase:        state_nxt = (wd == `FLASH_CMD_AA) ? wait_55 : wait_aa;
            default:      state_nxt = wait_aa;
        endcase
    end

    always_ff @(posedge SClk or negedge rst_n) begin
        if (!rst_n)
            state <= wait_aa;
        else if (psram_wr)
            state <= state_nxt;
    end

    assign emu_active  = emu.enable_flash_emu & info.ram_area;
    assign pass_read   = ~emu_active | (state != erase && state != fast_mode);
    assign pass_write  = ~emu_active | state == single_write | state == fast_write;
    assign catch_read  = ~pass_read & info.psram_hit;
    // erased flash reads as all ones
    assign catch_value = (state == erase) ? 8'hFF : 8'h00;

    a_state_legal: assert property (@(posedge SClk) disable iff (!rst_n)
        state inside {wait_aa, wait_55, cmd, fast_mode, fast_write, single_write, erase})
        else $error("flash emulator state out of range");

endmodule

//--- hw/cart_data_mux.sv
module cart_data_mux (
    input  cart_bus_pkg::bus_req_t   bus,
    input  cart_regs_pkg::map_info_t info,
    input  cart_regs_pkg::emu_ctrl_t emu,
    input  logic [7:0]               reg_rdata,
    input  logic                     reg_hit,
    input  logic                     catch_read,
    input  logic [7:0]               catch_value,
    output logic [15:0]              data_out,
    output logic                     data_oe_lo,
    output logic                     data_oe_hi
);

    logic sel_oe, hi_read, hi_write, io_out, emu_out;
    logic [7:0] data_lo, data_hi;

    assign sel_oe = ~bus.n_sel & ~bus.n_oe;

    // odd byte of an 8-bit access comes back on the low lane
    assign hi_read  = sel_oe & bus.n_io & info.psram_hi_lane & ~catch_read;
    assign hi_write = ~bus.n_sel & bus.n_io & ~bus.n_we & info.psram_hi_lane;
    assign io_out   = ~bus.n_io & reg_hit;
    assign emu_out  = bus.n_io & catch_read & emu.enable_flash_emu;

    always_comb begin
        if (hi_read)
            data_lo = bus.wdata[15:8];
        else if (io_out)
            data_lo = reg_rdata;
        else
            data_lo = catch_value;
    end

    assign data_hi    = hi_write ? bus.wdata[7:0] : 8'h00;
    assign data_out   = {data_hi, data_lo};
    assign data_oe_lo = (sel_oe & (io_out | emu_out)) | hi_read;
    assign data_oe_hi = hi_write;

    always_comb begin
        a_no_oe_idle: assert final (!bus.n_sel || (!data_oe_lo && !data_oe_hi))
            else $error("data lane enabled with n_sel high");
    end

endmodule

//--- hw/cart_mapper_top.sv
module cart_mapper_top (
    input  logic                   SClk,
    input  logic                   rst_n,
    input  cart_bus_pkg::bus_req_t bus,
    output cart_bus_pkg::mem_sel_t mem,
    output logic [15:0]            data_out,
    output logic                   data_oe_lo,
    output logic                   data_oe_hi
);

    import cart_regs_pkg::*;

    bank_regs_t regs;
    emu_ctrl_t  emu;
    map_info_t  info;
    logic [7:0] reg_rdata;
    logic       reg_hit;
    logic       pass_read, pass_write, catch_read;
    logic [7:0] catch_value;

    io_regs io_regs_i (
        .SClk      (SClk),
        .rst_n     (rst_n),
        .bus       (bus),
        .regs      (regs),
        .emu       (emu),
        .reg_rdata (reg_rdata),
        .reg_hit   (reg_hit)
    );

    bank_mapper bank_mapper_i (
        .bus        (bus),
        .regs       (regs),
        .emu        (emu),
        .pass_read  (pass_read),
        .pass_write (pass_write),
        .mem        (mem),
        .info       (info)
    );

    flash_emu_fsm flash_emu_fsm_i (
        .SClk        (SClk),
        .rst_n       (rst_n),
        .bus         (bus),
        .emu         (emu),
        .info        (info),
        .pass_read   (pass_read),
        .pass_write  (pass_write),
        .catch_read  (catch_read),
        .catch_value (catch_value)
    );

    cart_data_mux cart_data_mux_i (
        .bus         (bus),
        .info        (info),
        .emu         (emu),
        .reg_rdata   (reg_rdata),
        .reg_hit     (reg_hit),
        .catch_read  (catch_read),
        .catch_value (catch_value),
        .data_out    (data_out),
        .data_oe_lo  (data_oe_lo),
        .data_oe_hi  (data_oe_hi)
    );

endmodule

//--- verif/cart_mapper_tb.sv
`include "cart_params.svh"

module cart_mapper_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cart_bus_pkg::*;

    // stimulus is about 550 cycles including reset
    localparam int timeout_cycles = 2000;

    typedef enum logic [2:0] {
        st_wait_aa,
        st_wait_55,
        st_cmd,
        st_fast,
        st_fast_wr,
        st_single,
        st_erase
    } flash_model_e;

    logic        SClk;
    logic        rst_n;
    bus_req_t    bus;
    mem_sel_t    mem;
    logic [15:0] data_out;
    logic        data_oe_lo;
    logic        data_oe_hi;

    // register and flash model
    logic [9:0]   m_ram, m_rom0, m_rom1;
    logic [7:0]   m_lin, m_pow, m_mask_lo, m_mask_hi;
    logic         m_self_flash;
    logic [3:0]   m_emu;
    flash_model_e m_flash;

    // expected outputs
    logic [7:0] io_addr, io_val, wd;
    logic       io_known;
    logic       rom_sp, ram_sp, ram_ar, use_mask;
    logic [9:0] bank;
    logic [8:0] rom_val;
    logic [3:0] ram_val;
    logic       mem_cyc, rd, wr, emu_on, p_rd, p_wr, hit1, hit2, go;
    logic       byte_ar, hi_lane, caught, io_rd, hi_rd;
    logic [2:0] exp_sel, got_sel;
    logic [1:0] exp_lanes, got_lanes;
    logic [6:0] exp_addr;
    logic       exp_oe_lo, exp_oe_hi;
    logic [7:0] exp_lo;
    int         cycles = 0;

    logic [7:0] bank_addrs [10] = '{`REG_LINEAR, `REG_RAM_BANK, `REG_ROM0, `REG_ROM1,
        `REG_RAM_BANK_L, `REG_RAM_BANK_H, `REG_ROM0_L, `REG_ROM0_H, `REG_ROM1_L, `REG_ROM1_H};
    logic [7:0] cfg_addrs [13] = '{`REG_LINEAR, `REG_RAM_BANK, `REG_ROM0, `REG_ROM1,
        `REG_RAM_BANK_L, `REG_RAM_BANK_H, `REG_ROM0_L, `REG_ROM0_H, `REG_ROM1_L,
        `REG_ROM1_H, `REG_BANK_MASK_LO, `REG_BANK_MASK_HI, `REG_MEM_CTRL};

    cart_mapper_top dut_i (
        .SClk       (SClk),
        .rst_n      (rst_n),
        .bus        (bus),
        .mem        (mem),
        .data_out   (data_out),
        .data_oe_lo (data_oe_lo),
        .data_oe_hi (data_oe_hi)
    );

    initial begin
        SClk = 1'b0;
        forever #2 SClk = ~SClk;
    end

    always @(posedge SClk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic flash_model_e next_flash(input flash_model_e s, input logic [7:0] d);
        case (s)
            st_wait_aa: return (d == `FLASH_CMD_AA) ? st_wait_55 : st_wait_aa;
            st_wait_55: return (d == `FLASH_CMD_55) ? st_cmd : st_wait_aa;
            st_cmd: begin
                if (d == `FLASH_CMD_FAST)
                    return st_fast;
                if (d == `FLASH_CMD_WRITE)
                    return st_single;
                if (d == `FLASH_CMD_ERASE_A || d == `FLASH_CMD_ERASE_B)
                    return st_erase;
                return st_wait_aa;
            end
            st_fast: begin
                if (d == `FLASH_CMD_WRITE)
                    return st_fast_wr;
                if (d == `FLASH_CMD_EXIT)
                    return st_wait_aa;
                return st_fast;
            end
            st_fast_wr: return st_fast;
            st_erase:   return (d == `FLASH_CMD_AA) ? st_wait_55 : st_wait_aa;
            default:    return st_wait_aa;
        endcase
    endfunction

    assign io_addr   = {bus.addr_hi, bus.addr_lo[3:0]};
    assign wd        = bus.wdata[7:0];
    assign got_sel   = {mem.n_psram1_sel, mem.n_psram2_sel, mem.n_sram_sel};
    assign got_lanes = {mem.psram_n_lb, mem.psram_n_ub};

    // m_pow[4] is ext2003, m_pow[2] is extnile
    always @(posedge SClk or negedge rst_n) begin
        if (!rst_n) begin
            m_ram        <= 10'h3FF;
            m_rom0       <= 10'h3FF;
            m_rom1       <= 10'h3FF;
            m_lin        <= 8'hFF;
            m_pow        <= `POW_UNLOCK;
            m_mask_lo    <= 8'hFF;
            m_mask_hi    <= 8'hFF;
            m_self_flash <= 1'b0;
            m_emu        <= 4'h0;
            m_flash      <= st_wait_aa;
        end else if (!bus.n_sel && !bus.n_we && !bus.n_io) begin
            case (io_addr)
                `REG_LINEAR:       m_lin <= wd;
                `REG_RAM_BANK:     m_ram[7:0] <= wd;
                `REG_ROM0:         m_rom0[7:0] <= wd;
                `REG_ROM1:         m_rom1[7:0] <= wd;
                `REG_RAM_BANK_L:   if (m_pow[4]) m_ram[7:0] <= wd;
                `REG_RAM_BANK_H:   if (m_pow[4]) m_ram[9:8] <= wd[1:0];
                `REG_ROM0_L:       if (m_pow[4]) m_rom0[7:0] <= wd;
                `REG_ROM0_H:       if (m_pow[4]) m_rom0[9:8] <= wd[1:0];
                `REG_ROM1_L:       if (m_pow[4]) m_rom1[7:0] <= wd;
                `REG_ROM1_H:       if (m_pow[4]) m_rom1[9:8] <= wd[1:0];
                `REG_MEM_CTRL:     if (m_pow[4]) m_self_flash <= wd[0];
                `REG_BANK_MASK_LO: if (m_pow[2]) m_mask_lo <= wd;
                `REG_BANK_MASK_HI: if (m_pow[2]) m_mask_hi <= wd;
                `REG_POW_CNT:      if (m_pow[2] || wd == `POW_UNLOCK) m_pow <= wd;
                `REG_EMU_CNT:      if (m_pow[2]) m_emu <= wd[3:0];
                default: ;
            endcase
        end else if (!bus.n_sel && !bus.n_we && (hit1 || hit2)) begin
            m_flash <= next_flash(m_flash, wd);
        end
    end

    always_comb begin
        io_known = 1'b1;
        case (io_addr)
            `REG_LINEAR:                      io_val = m_lin;
            `REG_RAM_BANK, `REG_RAM_BANK_L:   io_val = m_ram[7:0];
            `REG_ROM0, `REG_ROM0_L:           io_val = m_rom0[7:0];
            `REG_ROM1, `REG_ROM1_L:           io_val = m_rom1[7:0];
            `REG_RAM_BANK_H:                  io_val = {6'h0, m_ram[9:8]};
            `REG_ROM0_H:                      io_val = {6'h0, m_rom0[9:8]};
            `REG_ROM1_H:                      io_val = {6'h0, m_rom1[9:8]};
            `REG_MEM_CTRL:                    io_val = {7'h0, m_self_flash};
            `REG_POW_CNT:                     io_val = m_pow;
            `REG_BANK_MASK_LO:                io_val = m_mask_lo;
            `REG_BANK_MASK_HI:                io_val = m_mask_hi;
            `REG_EMU_CNT:                     io_val = {4'h0, m_emu};
            default: begin
                io_val   = 8'h00;
                io_known = 1'b0;
            end
        endcase

        rom_sp   = 1'b0;
        ram_sp   = 1'b0;
        ram_ar   = 1'b0;
        use_mask = 1'b1;
        bank     = 10'h000;
        case (bus.addr_hi)
            4'h0: ;
            4'h1: begin
                ram_ar   = 1'b1;
                rom_sp   = m_self_flash;
                ram_sp   = ~m_self_flash;
                bank     = m_ram;
                use_mask = m_mask_hi[3];
            end
            4'h2: begin
                rom_sp   = 1'b1;
                bank     = m_rom0;
                use_mask = m_mask_hi[1];
            end
            4'h3: begin
                rom_sp   = 1'b1;
                bank     = m_rom1;
                use_mask = m_mask_hi[2];
            end
            default: begin
                rom_sp   = 1'b1;
                bank     = {1'b0, m_lin[4:0], bus.addr_hi};
                use_mask = 1'b0;
            end
        endcase
        rom_val = bank[8:0] & (use_mask ? {m_mask_hi[0], m_mask_lo} : 9'h1FF);
        ram_val = bank[3:0] & (use_mask ? m_mask_hi[7:4] : 4'hF);

        mem_cyc = !bus.n_sel && bus.n_io;
        rd      = !bus.n_oe;
        wr      = !bus.n_we;
        emu_on  = m_emu[2] && ram_ar;
        p_rd    = !emu_on || !(m_flash inside {st_erase, st_fast});
        p_wr    = !emu_on || (m_flash inside {st_single, st_fast_wr});
        hit1    = rom_sp && rom_val[8:7] == 2'd0;
        hit2    = rom_sp && rom_val[8:7] == 2'd1;
        go      = mem_cyc && ((rd && p_rd) || (wr && p_wr));
        exp_sel = {!(go && hit1), !(go && hit2),
                   !(mem_cyc && (rd || wr) && ram_sp && !ram_val[3] && m_pow[6])};

        // 8-bit accesses put the odd byte on the upper half of the psram
        byte_ar   = ram_ar || m_emu[3];
        exp_lanes = {byte_ar && bus.addr_lo[0], byte_ar && !bus.addr_lo[0]};
        exp_addr  = {rom_val[6:3], rom_sp ? rom_val[2:0] : ram_val[2:0]};
        hi_lane   = (hit1 || hit2) && byte_ar && bus.addr_lo[0];

        caught    = mem_cyc && rd && !p_rd && (hit1 || hit2);
        io_rd     = !bus.n_sel && !bus.n_io && rd && io_known;
        hi_rd     = mem_cyc && rd && hi_lane && !caught;
        exp_oe_lo = io_rd || caught || hi_rd;
        exp_oe_hi = mem_cyc && wr && hi_lane;
        if (hi_rd)
            exp_lo = bus.wdata[15:8];
        else if (io_rd)
            exp_lo = io_val;
        else
            exp_lo = (m_flash == st_erase) ? 8'hFF : 8'h00;
    end

    task automatic report_mismatch(input string sig, input logic [15:0] exp_v,
                                   input logic [15:0] got_v);
        $display("FAIL at %0t: %s expected %h got %h", $time, sig, exp_v, got_v);
        $display("Simulation finished: FAIL");
        $fatal(1, "output mismatch");
    endtask

    a_sel: assert property (@(negedge SClk) disable iff (!rst_n) got_sel == exp_sel)
        else report_mismatch("chip selects", 16'(exp_sel), 16'(got_sel));
    a_lanes: assert property (@(negedge SClk) disable iff (!rst_n) got_lanes == exp_lanes)
        else report_mismatch("psram_n_lb/ub", 16'(exp_lanes), 16'(got_lanes));
    a_addr: assert property (@(negedge SClk) disable iff (!rst_n)
        mem_cyc && bus.addr_hi != 4'h0 |-> mem.addr_ext == exp_addr)
        else report_mismatch("mem.addr_ext", 16'(exp_addr), 16'(mem.addr_ext));
    a_oe: assert property (@(negedge SClk) disable iff (!rst_n)
        {data_oe_lo, data_oe_hi} == {exp_oe_lo, exp_oe_hi})
        else report_mismatch("data_oe_lo/hi", 16'({exp_oe_lo, exp_oe_hi}),
                             16'({data_oe_lo, data_oe_hi}));
    a_lo: assert property (@(negedge SClk) disable iff (!rst_n)
        exp_oe_lo |-> data_out[7:0] == exp_lo)
        else report_mismatch("data_out[7:0]", 16'(exp_lo), 16'(data_out[7:0]));
    a_hi: assert property (@(negedge SClk) disable iff (!rst_n)
        exp_oe_hi |-> data_out[15:8] == bus.wdata[7:0])
        else report_mismatch("data_out[15:8]", 16'(bus.wdata[7:0]), 16'(data_out[15:8]));

    function automatic bus_req_t idle_req();
        bus_req_t r;
        r         = '0;
        r.n_sel   = 1'b1;
        r.n_io    = 1'b1;
        r.n_oe    = 1'b1;
        r.n_we    = 1'b1;
        return r;
    endfunction

    function automatic bus_req_t make_req(input logic io, input logic oe, input logic we,
                                          input logic [3:0] hi, input logic [8:0] lo,
                                          input logic [15:0] wdata);
        bus_req_t r;
        r.n_sel   = 1'b0;
        r.n_io    = io;
        r.n_oe    = oe;
        r.n_we    = we;
        r.addr_hi = hi;
        r.addr_lo = lo;
        r.wdata   = wdata;
        return r;
    endfunction

    // one active cycle followed by one idle cycle
    task automatic run_cycle(input bus_req_t req);
        @(posedge SClk);
        bus <= req;
        @(posedge SClk);
        bus <= idle_req();
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [7:0] val);
        run_cycle(make_req(1'b0, 1'b1, 1'b0, addr[7:4], {5'($urandom), addr[3:0]},
                           {8'($urandom), val}));
    endtask

    task automatic reg_read(input logic [7:0] addr);
        run_cycle(make_req(1'b0, 1'b0, 1'b1, addr[7:4], {5'($urandom), addr[3:0]},
                           16'($urandom)));
    endtask

    // wdata doubles as the psram data on reads
    task automatic mem_read(input logic [3:0] hi, input logic [8:0] lo);
        run_cycle(make_req(1'b1, 1'b0, 1'b1, hi, lo, 16'($urandom)));
    endtask

    task automatic mem_write(input logic [3:0] hi, input logic [8:0] lo, input logic [15:0] d);
        run_cycle(make_req(1'b1, 1'b1, 1'b0, hi, lo, d));
    endtask

    task automatic flash_cmd(input logic [7:0] b);
        mem_write(4'h1, 9'($urandom), {8'($urandom), b});
    endtask

    initial begin
        int unsigned seed_ret;
        int          pick;

        seed_ret = $urandom(32'hbfbb_8b2d);
        rst_n = 1'b0;
        bus   = idle_req();
        repeat (16) @(posedge SClk);
        rst_n <= 1'b1;

        // reset values
        reg_read(`REG_POW_CNT);
        reg_read(`REG_ROM0);
        mem_read(4'h2, 9'h000);
        mem_read(4'h1, 9'h001);

        for (int i = 0; i < 16; i++) begin
            pick = $urandom_range(0, 9);
            reg_write(bank_addrs[pick], 8'($urandom));
            reg_read(bank_addrs[pick]);
        end
        // ext2003 clear makes the 2003 bank registers read only
        reg_write(`REG_POW_CNT, 8'hCD);
        reg_write(`REG_ROM0_L, 8'($urandom));
        reg_read(`REG_ROM0_L);
        reg_write(`REG_POW_CNT, `POW_UNLOCK);
        // with extnile clear only the unlock byte reaches POW_CNT
        reg_write(`REG_POW_CNT, 8'hD9);
        reg_write(`REG_POW_CNT, 8'h5F);
        reg_read(`REG_POW_CNT);
        reg_write(`REG_EMU_CNT, 8'h0F);
        reg_read(`REG_EMU_CNT);
        reg_write(`REG_POW_CNT, `POW_UNLOCK);
        reg_read(`REG_POW_CNT);

        for (int i = 0; i < 48; i++) begin
            if (i % 8 == 0)
                reg_write(`REG_POW_CNT, {1'b1, 1'($urandom), 6'b011101});
            pick = $urandom_range(0, 12);
            reg_write(cfg_addrs[pick], 8'($urandom));
            mem_read(4'($urandom), 9'($urandom));
            mem_write(4'($urandom), 9'($urandom), 16'($urandom));
        end

        // save area on sram in bank 2
        reg_write(`REG_POW_CNT, `POW_UNLOCK);
        reg_write(`REG_BANK_MASK_LO, 8'hFF);
        reg_write(`REG_BANK_MASK_HI, 8'hFF);
        reg_write(`REG_RAM_BANK_H, 8'h00);
        reg_write(`REG_RAM_BANK_L, 8'h02);
        reg_write(`REG_MEM_CTRL, 8'h00);
        mem_read(4'h1, 9'h010);
        mem_read(4'h1, 9'h011);
        mem_write(4'h1, 9'h013, 16'($urandom));
        reg_write(`REG_POW_CNT, 8'h9D);
        mem_read(4'h1, 9'h012);
        mem_write(4'h1, 9'h014, 16'($urandom));
        reg_write(`REG_POW_CNT, `POW_UNLOCK);
        // save area moved onto psram1
        reg_write(`REG_MEM_CTRL, 8'h01);
        mem_write(4'h1, 9'h021, 16'($urandom));
        mem_read(4'h1, 9'h021);
        reg_write(`REG_ROM0_H, 8'h00);
        reg_write(`REG_ROM0_L, 8'h40);
        reg_write(`REG_EMU_CNT, 8'h08);
        mem_read(4'h2, 9'h031);
        mem_write(4'h2, 9'h031, 16'($urandom));
        reg_write(`REG_EMU_CNT, 8'h00);

        // two exit bytes bring the flash command FSM home from any state
        reg_write(`REG_EMU_CNT, 8'h04);
        flash_cmd(`FLASH_CMD_EXIT);
        flash_cmd(`FLASH_CMD_EXIT);
        mem_write(4'h1, 9'h008, 16'($urandom));
        flash_cmd(`FLASH_CMD_AA);
        flash_cmd(`FLASH_CMD_55);
        flash_cmd(`FLASH_CMD_WRITE);
        mem_write(4'h1, 9'h010, 16'($urandom));
        mem_write(4'h1, 9'h012, 16'($urandom));
        mem_read(4'h1, 9'h010);

        flash_cmd(`FLASH_CMD_AA);
        flash_cmd(`FLASH_CMD_55);
        flash_cmd(`FLASH_CMD_ERASE_B);
        mem_read(4'h1, 9'h004);
        mem_read(4'h1, 9'h005);
        flash_cmd(8'h00);

        flash_cmd(`FLASH_CMD_AA);
        flash_cmd(`FLASH_CMD_55);
        flash_cmd(`FLASH_CMD_FAST);
        mem_read(4'h1, 9'h006);
        mem_read(4'h1, 9'h007);
        flash_cmd(`FLASH_CMD_WRITE);
        mem_write(4'h1, 9'h015, 16'($urandom));
        mem_read(4'h1, 9'h015);
        flash_cmd(`FLASH_CMD_EXIT);
        mem_read(4'h1, 9'h015);

        repeat (4) @(posedge SClk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- cart_mapper_top.f
+incdir+common
common/cart_bus_pkg.sv
common/cart_regs_pkg.sv
hw/io_regs.sv
mapper/bank_mapper.sv
mapper/flash_emu_fsm.sv
hw/cart_data_mux.sv
hw/cart_mapper_top.sv
verif/cart_mapper_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cart_mapper_tb -f cart_mapper_top.f

out=$(./obj_dir/Vcart_mapper_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF "Simulation finished: PASS"
